// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_leaf_i2o3
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
leaf_pkg.sv
leaf_rx.sv
leaf_tx.sv
kernel_lane.sv
kernel_combine.sv
user_kernel.sv
leaf_i2o3.sv
tb_leaf_i2o3.sv

// ==== kernel_combine.sv ====
module kernel_combine (
    input  logic                                             clk_400,
    input  logic                                             arst_n,
    input  leaf_pkg::stream_t                                lane_a,
    input  leaf_pkg::stream_t                                lane_b,
    output logic                                             take_a,
    output logic                                             take_b,
    output leaf_pkg::payload_t [leaf_pkg::NUM_OUT_PORTS-1:0] out_data,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]               out_vld,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]               out_ack
);

    localparam int LANES = leaf_pkg::NUM_IN_PORTS;
    localparam int PAIR  = leaf_pkg::NUM_OUT_PORTS - 1;  // xor output.

    leaf_pkg::stream_t  lane [LANES];
    logic [LANES-1:0]   take;
    leaf_pkg::payload_t slot [LANES];
    logic [LANES-1:0]   slot_full;
    logic               pair_go;

    assign lane[0] = lane_a;
    assign lane[1] = lane_b;

    // a lane is taken only when its output and its pair slot are both empty.
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            take[i] = lane[i].vld && !out_vld[i] && !slot_full[i];
        end
    end

    assign take_a  = take[0];
    assign take_b  = take[1];
    assign pair_go = (&slot_full) && (!out_vld[PAIR] || out_ack[PAIR]);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output and slot occupancy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            out_vld   <= '0;
            slot_full <= '0;
        end else begin
            for (int i = 0; i < LANES; i++) begin
                if (take[i]) begin
                    out_vld[i]   <= 1'b1;
                    slot_full[i] <= 1'b1;
                end else begin
                    if (out_ack[i]) begin
                        out_vld[i] <= 1'b0;
                    end
                    if (pair_go) begin
                        slot_full[i] <= 1'b0;  // both slots drain together.
                    end
                end
            end
            if (pair_go) begin
                out_vld[PAIR] <= 1'b1;
            end else if (out_ack[PAIR]) begin
                out_vld[PAIR] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_400) begin
        for (int i = 0; i < LANES; i++) begin
            if (take[i]) begin
                out_data[i] <= lane[i].data;
                slot[i]     <= lane[i].data;
            end
        end
        if (pair_go) begin
            out_data[PAIR] <= slot[0] ^ slot[1];
        end
    end

endmodule

// ==== kernel_lane.sv ====
module kernel_lane (
    input  logic               clk_400,
    input  logic               arst_n,
    input  logic               run,
    input  leaf_pkg::payload_t data,
    input  logic               vld,
    output logic               ack,
    output leaf_pkg::stream_t  result,
    input  logic               take
);

    leaf_pkg::payload_t sum;
    logic               pend;      // sum not yet offered.
    logic               res_vld;
    leaf_pkg::payload_t res_data;
    logic               res_free;
    logic               move;
    logic               accept;

    assign res_free = !res_vld || take;
    assign move     = pend && res_free;
    assign ack      = run && (!pend || res_free);
    assign accept   = vld && ack;

    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            sum     <= '0;
            pend    <= 1'b0;
            res_vld <= 1'b0;
        end else if (!run) begin
            sum     <= '0;
            pend    <= 1'b0;
            res_vld <= 1'b0;
        end else begin
            if (accept) begin
                sum  <= sum + data;  // wraps.
                pend <= 1'b1;
            end else if (move) begin
                pend <= 1'b0;
            end
            if (move) begin
                res_vld <= 1'b1;
            end else if (take) begin
                res_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_400) begin
        if (move) begin
            res_data <= sum;
        end
    end

    assign result.vld  = res_vld;
    assign result.data = res_data;

endmodule

// ==== leaf_i2o3.sv ====
module leaf_i2o3 #(
    parameter int RX_DEPTH = 4
) (
    input  logic              clk_400,
    input  logic              arst_n,
    input  leaf_pkg::packet_t din_leaf_bft2interface,
    output leaf_pkg::packet_t dout_leaf_interface2bft,
    input  logic              resend,
    input  logic              ap_start
);

    leaf_pkg::payload_t [leaf_pkg::NUM_IN_PORTS-1:0]  in_data;
    logic [leaf_pkg::NUM_IN_PORTS-1:0]                in_vld;
    logic [leaf_pkg::NUM_IN_PORTS-1:0]                in_ack;
    leaf_pkg::payload_t [leaf_pkg::NUM_OUT_PORTS-1:0] out_data;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0]               out_vld;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0]               out_ack;
    leaf_pkg::route_t [leaf_pkg::NUM_OUT_PORTS-1:0]   routes;

    leaf_rx #(
        .RX_DEPTH (RX_DEPTH)
    ) rx_inst (
        .clk_400                (clk_400),
        .arst_n                 (arst_n),
        .din_leaf_bft2interface (din_leaf_bft2interface),
        .in_data                (in_data),
        .in_vld                 (in_vld),
        .in_ack                 (in_ack),
        .routes                 (routes)
    );

    user_kernel user_kernel_inst (
        .clk_400  (clk_400),
        .arst_n   (arst_n),
        .ap_start (ap_start),
        .in_data  (in_data),
        .in_vld   (in_vld),
        .in_ack   (in_ack),
        .out_data (out_data),
        .out_vld  (out_vld),
        .out_ack  (out_ack)
    );

    leaf_tx tx_inst (
        .clk_400                 (clk_400),
        .arst_n                  (arst_n),
        .resend                  (resend),
        .out_data                (out_data),
        .out_vld                 (out_vld),
        .out_ack                 (out_ack),
        .routes                  (routes),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

endmodule

// ==== leaf_pkg.sv ====
package leaf_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tree packet geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int PACKET_BITS  = 49;
    localparam int PAYLOAD_BITS = 32;
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int ADDR_BITS    = 7;

    localparam int NUM_IN_PORTS  = 2;
    localparam int NUM_OUT_PORTS = 3;

    typedef logic [PACKET_BITS-1:0]  packet_t;
    typedef logic [PAYLOAD_BITS-1:0] payload_t;
    typedef logic [LEAF_BITS-1:0]    leaf_id_t;
    typedef logic [PORT_BITS-1:0]    port_id_t;
    typedef logic [ADDR_BITS-1:0]    addr_t;

    // index of one kernel output.
    typedef logic [$clog2(NUM_OUT_PORTS)-1:0] out_sel_t;

    localparam port_id_t CFG_PORT = port_id_t'(0);  // routing table writes.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // packet layout, top bit first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic     valid;
        leaf_id_t dst_leaf;
        port_id_t dst_port;
        addr_t    addr;       // sequence number on outgoing packets.
        payload_t payload;
    } pkt_fields_t;

    // one routing table entry.
    typedef struct packed {
        leaf_id_t dst_leaf;
        port_id_t dst_port;
    } route_t;

    // lane result towards the combiner.
    typedef struct packed {
        logic     vld;
        payload_t data;
    } stream_t;

endpackage

// ==== leaf_rx.sv ====
module leaf_rx #(
    parameter int RX_DEPTH = 4
) (
    input  logic                                            clk_400,
    input  logic                                            arst_n,
    input  leaf_pkg::packet_t                               din_leaf_bft2interface,
    output leaf_pkg::payload_t [leaf_pkg::NUM_IN_PORTS-1:0] in_data,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]               in_vld,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0]               in_ack,
    output leaf_pkg::route_t [leaf_pkg::NUM_OUT_PORTS-1:0]  routes
);

    localparam int PTR_BITS = $clog2(RX_DEPTH);

    leaf_pkg::pkt_fields_t pkt_in;
    leaf_pkg::pkt_fields_t pkt_q;
    logic                  pkt_valid_q;

    assign pkt_in = leaf_pkg::pkt_fields_t'(din_leaf_bft2interface);

    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            pkt_valid_q <= 1'b0;
        end else begin
            pkt_valid_q <= pkt_in.valid;
        end
    end

    always_ff @(posedge clk_400) begin
        pkt_q <= pkt_in;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // routing table, addr 1..3 selects the output
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            routes <= '0;
        end else if (pkt_valid_q && pkt_q.dst_port == leaf_pkg::CFG_PORT) begin
            for (int j = 0; j < leaf_pkg::NUM_OUT_PORTS; j++) begin
                if (pkt_q.addr == leaf_pkg::addr_t'(j + 1)) begin
                    routes[j] <= leaf_pkg::route_t'(pkt_q.payload[$bits(leaf_pkg::route_t)-1:0]);
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // receive queues for data ports 1 and 2
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin : g_queue
        leaf_pkg::payload_t mem [RX_DEPTH];
        logic [PTR_BITS:0]  wr_ptr;
        logic [PTR_BITS:0]  rd_ptr;
        logic               full;
        logic               push;
        logic               pop;

        assign full = (wr_ptr[PTR_BITS] != rd_ptr[PTR_BITS]) &&
                      (wr_ptr[PTR_BITS-1:0] == rd_ptr[PTR_BITS-1:0]);
        assign push = pkt_valid_q && !full &&
                      pkt_q.dst_port == leaf_pkg::port_id_t'(i + 1);  // full queue drops.
        assign pop  = in_vld[i] && in_ack[i];

        assign in_vld[i]  = (wr_ptr != rd_ptr);
        assign in_data[i] = mem[rd_ptr[PTR_BITS-1:0]];

        always_ff @(posedge clk_400) begin
            if (push) begin
                mem[wr_ptr[PTR_BITS-1:0]] <= pkt_q.payload;
            end
        end

        always_ff @(posedge clk_400 or negedge arst_n) begin
            if (!arst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

endmodule

// ==== leaf_tx.sv ====
module leaf_tx (
    input  logic                                             clk_400,
    input  logic                                             arst_n,
    input  logic                                             resend,
    input  leaf_pkg::payload_t [leaf_pkg::NUM_OUT_PORTS-1:0] out_data,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]               out_vld,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]               out_ack,
    input  leaf_pkg::route_t [leaf_pkg::NUM_OUT_PORTS-1:0]   routes,
    output leaf_pkg::packet_t                                dout_leaf_interface2bft
);

    localparam int N = leaf_pkg::NUM_OUT_PORTS;

    leaf_pkg::out_sel_t    rr_ptr;
    leaf_pkg::out_sel_t    sel;
    logic                  hit;
    logic                  grant;
    logic                  move;
    leaf_pkg::addr_t       seq [N];

    // capture stage.
    logic                  cap_vld;
    leaf_pkg::out_sel_t    cap_idx;
    leaf_pkg::addr_t       cap_addr;
    leaf_pkg::payload_t    cap_data;

    // packet stage.
    logic                  pkt_vld;
    leaf_pkg::route_t      pkt_route;
    leaf_pkg::addr_t       pkt_addr;
    leaf_pkg::payload_t    pkt_data;
    leaf_pkg::pkt_fields_t pkt;

    // first valid output at or after the round-robin pointer.
    always_comb begin : pick
        int cand;
        sel = rr_ptr;
        hit = 1'b0;
        for (int k = 0; k < N; k++) begin
            cand = int'(rr_ptr) + k;
            if (cand >= N) begin
                cand = cand - N;
            end
            if (!hit && out_vld[cand]) begin
                hit = 1'b1;
                sel = leaf_pkg::out_sel_t'(cand);
            end
        end
    end

    assign move  = cap_vld && (!pkt_vld || !resend);  // packet stage free or sending.
    assign grant = !resend && hit;

    always_comb begin
        out_ack = '0;
        if (grant) begin
            out_ack[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            rr_ptr  <= '0;
            cap_vld <= 1'b0;
            pkt_vld <= 1'b0;
            for (int j = 0; j < N; j++) begin
                seq[j] <= '0;
            end
        end else begin
            if (grant) begin
                cap_vld  <= 1'b1;
                seq[sel] <= seq[sel] + 1'b1;
                rr_ptr   <= (sel == leaf_pkg::out_sel_t'(N - 1)) ? '0 : sel + 1'b1;
            end else if (move) begin
                cap_vld <= 1'b0;
            end
            if (move) begin
                pkt_vld <= 1'b1;
            end else if (!resend) begin
                pkt_vld <= 1'b0;  // sent on this edge.
            end
        end
    end

    always_ff @(posedge clk_400) begin
        if (grant) begin
            cap_idx  <= sel;
            cap_addr <= seq[sel];
            cap_data <= out_data[sel];
        end
        if (move) begin
            pkt_route <= routes[cap_idx];
            pkt_addr  <= cap_addr;
            pkt_data  <= cap_data;
        end
    end

    assign pkt.valid    = pkt_vld;
    assign pkt.dst_leaf = pkt_route.dst_leaf;
    assign pkt.dst_port = pkt_route.dst_port;
    assign pkt.addr     = pkt_addr;
    assign pkt.payload  = pkt_data;

    assign dout_leaf_interface2bft = resend ? '0 : leaf_pkg::packet_t'(pkt);

endmodule

// ==== tb_leaf_i2o3.sv ====
module tb_leaf_i2o3;

    localparam int MAX_CYCLES = 4000;  // about ten times the length of the stimulus.

    logic                  clk_400;
    logic                  arst_n;
    leaf_pkg::packet_t     din;
    leaf_pkg::packet_t     dout;
    logic                  resend;
    logic                  ap_start;
    leaf_pkg::pkt_fields_t dout_f;

    leaf_pkg::route_t      cfg_route [3];
    leaf_pkg::packet_t     exp_q [3][$];      // expected packets per output.
    leaf_pkg::payload_t    sum_hist [2][$];   // lane sums waiting for a partner.
    leaf_pkg::payload_t    run_sum [2];
    leaf_pkg::addr_t       exp_seq [3];
    logic [31:0]           lcg_state = 32'd29858;

    leaf_i2o3 #(
        .RX_DEPTH (4)
    ) leaf_i2o3_i (
        .clk_400                 (clk_400),
        .arst_n                  (arst_n),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout),
        .resend                  (resend),
        .ap_start                (ap_start)
    );

    assign dout_f = leaf_pkg::pkt_fields_t'(dout);

    initial begin
        clk_400 = 1'b0;
        forever #20 clk_400 = ~clk_400;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic leaf_pkg::packet_t make_packet(logic valid, leaf_pkg::port_id_t port,
                                                      leaf_pkg::addr_t addr,
                                                      leaf_pkg::payload_t payload);
        leaf_pkg::pkt_fields_t f;
        f.valid    = valid;
        f.dst_leaf = leaf_pkg::leaf_id_t'(1);  // this leaf.
        f.dst_port = port;
        f.addr     = addr;
        f.payload  = payload;
        return leaf_pkg::packet_t'(f);
    endfunction

    // outgoing packet built from the route, sequence count and data of one output.
    function automatic leaf_pkg::packet_t expected_packet(int idx, leaf_pkg::addr_t seq,
                                                          leaf_pkg::payload_t data);
        leaf_pkg::pkt_fields_t f;
        f.valid    = 1'b1;
        f.dst_leaf = cfg_route[idx].dst_leaf;
        f.dst_port = cfg_route[idx].dst_port;
        f.addr     = seq;
        f.payload  = data;
        return leaf_pkg::packet_t'(f);
    endfunction

    function automatic int find_output(leaf_pkg::pkt_fields_t p);
        for (int i = 0; i < 3; i++) begin
            if (p.dst_leaf == cfg_route[i].dst_leaf && p.dst_port == cfg_route[i].dst_port) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_field(string name, logic [31:0] exp, logic [31:0] act);
        assert (exp === act) else begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic push_expected(int idx, leaf_pkg::payload_t data);
        exp_q[idx].push_back(expected_packet(idx, exp_seq[idx], data));
        exp_seq[idx] = exp_seq[idx] + 1'b1;
    endtask

    task automatic send_packet(leaf_pkg::packet_t p);
        @(negedge clk_400);
        din = p;
        @(negedge clk_400);
        din = '0;
    endtask

    // one data word into input idx with its running sum and any new pair.
    task automatic send_word(int idx, leaf_pkg::payload_t word);
        leaf_pkg::payload_t a;
        leaf_pkg::payload_t b;
        send_packet(make_packet(1'b1, leaf_pkg::port_id_t'(idx + 1), '0, word));
        run_sum[idx] = run_sum[idx] + word;
        push_expected(idx, run_sum[idx]);
        sum_hist[idx].push_back(run_sum[idx]);
        while (sum_hist[0].size() > 0 && sum_hist[1].size() > 0) begin
            a = sum_hist[0].pop_front();
            b = sum_hist[1].pop_front();
            push_expected(2, a ^ b);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // monitor and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : monitor
        int                    idx;
        leaf_pkg::pkt_fields_t exp_f;
        forever begin
            @(posedge clk_400);
            if (resend) begin
                assert (dout == '0) else begin
                    $display("mismatch dout_leaf_interface2bft: expected %h, actual %h",
                             leaf_pkg::packet_t'(0), dout);
                    stop_on_error();
                end
            end else if (dout_f.valid) begin
                idx = find_output(dout_f);
                assert (idx >= 0) else begin
                    $display("an outgoing packet carries a route that no output owns");
                    stop_on_error();
                end
                assert (exp_q[idx].size() > 0) else begin
                    $display("output %0d sent a packet that was not expected", idx + 1);
                    stop_on_error();
                end
                exp_f = leaf_pkg::pkt_fields_t'(exp_q[idx].pop_front());
                check_field("addr", 32'(exp_f.addr), 32'(dout_f.addr));
                check_field("payload", exp_f.payload, dout_f.payload);
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk_400);
            cycles++;
            if (cycles >= MAX_CYCLES) begin
                $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
                stop_on_error();
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : stimulus
        din      = '0;
        resend   = 1'b0;
        ap_start = 1'b0;
        arst_n   = 1'b0;
        cfg_route[0] = '{dst_leaf: 5'd3, dst_port: 4'd5};
        cfg_route[1] = '{dst_leaf: 5'd17, dst_port: 4'd9};
        cfg_route[2] = '{dst_leaf: 5'd30, dst_port: 4'd2};
        run_sum = '{default: '0};
        exp_seq = '{default: '0};
        repeat (16) @(posedge clk_400);
        @(negedge clk_400);
        arst_n = 1'b1;

        // the kernel is idle so these words only wait in the receive queues.
        for (int k = 0; k < 2; k++) begin
            send_word(0, next_random());
            send_word(1, next_random());
        end
        repeat (20) begin
            @(posedge clk_400);
            assert (!dout_f.valid) else begin
                $display("a packet left the leaf before ap_start");
                stop_on_error();
            end
        end

        for (int k = 0; k < 3; k++) begin
            send_packet(make_packet(1'b1, leaf_pkg::CFG_PORT, leaf_pkg::addr_t'(k + 1),
                                    leaf_pkg::payload_t'(cfg_route[k])));
        end
        send_packet(make_packet(1'b1, leaf_pkg::CFG_PORT, 7'd4, '1));  // no such output.
        @(negedge clk_400);
        ap_start = 1'b1;
        @(negedge clk_400);
        ap_start = 1'b0;

        for (int k = 0; k < 20; k++) begin
            send_word(0, next_random());
            send_word(1, next_random());
            if (k == 6) begin
                send_packet(make_packet(1'b1, 4'd7, '0, next_random()));
                send_packet(make_packet(1'b0, 4'd1, '0, next_random()));
                send_packet(make_packet(1'b0, leaf_pkg::CFG_PORT, 7'd1, '0));
            end
            if (k == 9) begin
                resend = 1'b1;
                repeat (30) @(negedge clk_400);
                resend = 1'b0;
            end
            repeat (3 + int'(next_random() % 32'd5)) @(negedge clk_400);
        end

        while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0) begin
            @(posedge clk_400);
        end
        repeat (40) @(posedge clk_400);

        if (leaf_i2o3_i.rx_inst.in_vld == '0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("queues still hold data at the end of the run");
            stop_on_error();
        end
    end

endmodule

// ==== user_kernel.sv ====
module user_kernel (
    input  logic                                             clk_400,
    input  logic                                             arst_n,
    input  logic                                             ap_start,
    input  leaf_pkg::payload_t [leaf_pkg::NUM_IN_PORTS-1:0]  in_data,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0]                in_vld,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]                in_ack,
    output leaf_pkg::payload_t [leaf_pkg::NUM_OUT_PORTS-1:0] out_data,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]               out_vld,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]               out_ack
);

    logic                                run;
    leaf_pkg::stream_t                   lane_res [leaf_pkg::NUM_IN_PORTS];
    logic [leaf_pkg::NUM_IN_PORTS-1:0]   lane_take;

    // sticky until reset.
    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            run <= 1'b0;
        end else if (ap_start) begin
            run <= 1'b1;
        end
    end

    for (genvar i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin : g_lane
        kernel_lane lane_inst (
            .clk_400 (clk_400),
            .arst_n  (arst_n),
            .run     (run),
            .data    (in_data[i]),
            .vld     (in_vld[i]),
            .ack     (in_ack[i]),
            .result  (lane_res[i]),
            .take    (lane_take[i])
        );
    end

    kernel_combine combine_inst (
        .clk_400  (clk_400),
        .arst_n   (arst_n),
        .lane_a   (lane_res[0]),
        .lane_b   (lane_res[1]),
        .take_a   (lane_take[0]),
        .take_b   (lane_take[1]),
        .out_data (out_data),
        .out_vld  (out_vld),
        .out_ack  (out_ack)
    );

endmodule
